// File: hdl/risc16_cfg.svh
// Fixed sizes and instruction field positions of the RiSC-16 core
// Included by the package and by modules that slice instruction words
`ifndef RISC16_CFG_SVH
`define RISC16_CFG_SVH

// Data, address, PC and instruction width
`define RISC16_WORD_W      16

// Register file
`define RISC16_REG_ADDR_W  3
`define RISC16_NUM_REGS    8

// ----------------------------------------------------------------------
// Instruction word layout
// ----------------------------------------------------------------------
`define RISC16_OPCODE_W    3
`define RISC16_OPCODE_MSB  15
`define RISC16_RA_MSB      12
`define RISC16_RB_MSB      9
`define RISC16_RC_MSB      2

// Both immediates sit at bit 0
`define RISC16_SIMM_W      7
`define RISC16_LIMM_W      10

`endif

// File: hdl/risc16_pkg.sv
// Shared types of the RiSC-16 pipeline
// Stage registers and forwarding sources are passed between modules as these structs
`include "risc16_cfg.svh"

package risc16_pkg;

    typedef logic [`RISC16_WORD_W-1:0]     word_t;
    typedef logic [`RISC16_REG_ADDR_W-1:0] reg_addr_t;

    // Opcodes 6 and 7 were control flow, now no-ops
    typedef enum logic [`RISC16_OPCODE_W-1:0] {
        OP_ADD   = 3'd0,
        OP_ADDI  = 3'd1,
        OP_NAND  = 3'd2,
        OP_LUI   = 3'd3,
        OP_SW    = 3'd4,
        OP_LW    = 3'd5,
        OP_RSVD6 = 3'd6,
        OP_RSVD7 = 3'd7
    } opcode_e;

    typedef enum logic {
        ALU_ADD  = 1'b0,
        ALU_NAND = 1'b1
    } alu_op_e;

    // ------------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------------

    // Decode register, sources already chosen per opcode
    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        reg_addr_t tgt;
        reg_addr_t src1;
        reg_addr_t src2;
        word_t     imm;
    } decode_stage_t;

    // Execute register, also drives the data-memory port
    typedef struct packed {
        logic      valid;
        logic      is_load;
        logic      is_store;
        reg_addr_t tgt;
        word_t     alu_result;
        word_t     store_data;
    } exec_stage_t;

    // One result on its way to the register file
    typedef struct packed {
        logic      valid;
        reg_addr_t tgt;
        word_t     data;
    } result_fwd_t;

endpackage

// File: hdl/risc16_fetch.sv
// Fetch stage: program counter and the fetch register
// The PC steps by one word per cycle and holds with the fetch register on a stall
module risc16_fetch (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_stall,
    input  risc16_pkg::word_t i_inst,
    output risc16_pkg::word_t o_pc,
    output risc16_pkg::word_t o_inst,
    output logic              o_valid
);

    // PC and valid bit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc    <= '0;
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_pc    <= o_pc + 1'b1;
            o_valid <= 1'b1;
        end
    end

    // Instruction word, qualified by o_valid
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_inst <= i_inst;
        end
    end

endmodule

// File: hdl/risc16_decode.sv
// Decode stage: field split, immediates, register indices and load-use check
// Read indices come from the decode register so the register file data
// lines up with the instruction in execute
`include "risc16_cfg.svh"

module risc16_decode (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  risc16_pkg::word_t         i_inst,
    input  logic                      i_valid,
    input  risc16_pkg::exec_stage_t   i_exec,
    output risc16_pkg::reg_addr_t     o_rd_src1,
    output risc16_pkg::reg_addr_t     o_rd_src2,
    output risc16_pkg::decode_stage_t o_dec,
    output logic                      o_load_stall
);

    risc16_pkg::opcode_e       opcode;
    risc16_pkg::reg_addr_t     reg_a;
    risc16_pkg::reg_addr_t     reg_b;
    risc16_pkg::reg_addr_t     reg_c;
    logic [`RISC16_SIMM_W-1:0] simm;
    logic [`RISC16_LIMM_W-1:0] limm;
    risc16_pkg::word_t         simm_ext;
    risc16_pkg::word_t         limm_ext;
    risc16_pkg::decode_stage_t dec_next;

    // ----------------------------------------------------------------------
    // Field split
    // ----------------------------------------------------------------------
    assign opcode = risc16_pkg::opcode_e'(i_inst[`RISC16_OPCODE_MSB -: `RISC16_OPCODE_W]);
    assign reg_a  = i_inst[`RISC16_RA_MSB -: `RISC16_REG_ADDR_W];
    assign reg_b  = i_inst[`RISC16_RB_MSB -: `RISC16_REG_ADDR_W];
    assign reg_c  = i_inst[`RISC16_RC_MSB -: `RISC16_REG_ADDR_W];
    assign simm   = i_inst[`RISC16_SIMM_W-1:0];
    assign limm   = i_inst[`RISC16_LIMM_W-1:0];

    // Sign-extend short form, long form goes to the top bits
    assign simm_ext = {{(`RISC16_WORD_W - `RISC16_SIMM_W){simm[`RISC16_SIMM_W-1]}}, simm};
    assign limm_ext = {limm, {(`RISC16_WORD_W - `RISC16_LIMM_W){1'b0}}};

    // Target and sources per opcode; anything else leaves an all-zero bubble
    always_comb begin
        dec_next = '0;
        if (i_valid) begin
            case (opcode)
                risc16_pkg::OP_ADD,
                risc16_pkg::OP_NAND: begin
                    dec_next.valid  = 1'b1;
                    dec_next.opcode = opcode;
                    dec_next.tgt    = reg_a;
                    dec_next.src1   = reg_b;
                    dec_next.src2   = reg_c;
                end
                risc16_pkg::OP_ADDI,
                risc16_pkg::OP_LW: begin
                    dec_next.valid  = 1'b1;
                    dec_next.opcode = opcode;
                    dec_next.tgt    = reg_a;
                    dec_next.src1   = reg_b;
                    dec_next.imm    = simm_ext;
                end
                risc16_pkg::OP_LUI: begin
                    dec_next.valid  = 1'b1;
                    dec_next.opcode = opcode;
                    dec_next.tgt    = reg_a;
                    dec_next.imm    = limm_ext;
                end
                // rA is the data to store, no target
                risc16_pkg::OP_SW: begin
                    dec_next.valid  = 1'b1;
                    dec_next.opcode = opcode;
                    dec_next.src1   = reg_b;
                    dec_next.src2   = reg_a;
                    dec_next.imm    = simm_ext;
                end
                default: begin
                    dec_next.valid = 1'b0;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Load-use hazard against the execute register
    // ----------------------------------------------------------------------
    assign o_load_stall = i_exec.valid && i_exec.is_load && (i_exec.tgt != '0) &&
                          ((i_exec.tgt == o_dec.src1) || (i_exec.tgt == o_dec.src2));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec <= '0;
        end else if (!o_load_stall) begin
            o_dec <= dec_next;
        end
    end

    assign o_rd_src1 = o_dec.src1;
    assign o_rd_src2 = o_dec.src2;

endmodule

// File: hdl/risc16_regfile.sv
// Eight-entry register file, two asynchronous reads and one write
// r0 has no storage and always reads as zero
`include "risc16_cfg.svh"

module risc16_regfile (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  risc16_pkg::reg_addr_t   i_rd_src1,
    input  risc16_pkg::reg_addr_t   i_rd_src2,
    output risc16_pkg::word_t       o_rd_data1,
    output risc16_pkg::word_t       o_rd_data2,
    input  risc16_pkg::result_fwd_t i_wr
);

    risc16_pkg::word_t regs [1:`RISC16_NUM_REGS-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < `RISC16_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.valid && (i_wr.tgt != '0)) begin
            regs[i_wr.tgt] <= i_wr.data;
        end
    end

    assign o_rd_data1 = (i_rd_src1 == '0) ? '0 : regs[i_rd_src1];
    assign o_rd_data2 = (i_rd_src2 == '0) ? '0 : regs[i_rd_src2];

endmodule

// File: hdl/risc16_execute.sv
// Execute stage: operand forwarding, ALU and the execute register
// The execute register drives the data-memory port directly
module risc16_execute (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_stall,
    input  risc16_pkg::decode_stage_t i_dec,
    input  risc16_pkg::word_t         i_rd_data1,
    input  risc16_pkg::word_t         i_rd_data2,
    input  risc16_pkg::result_fwd_t   i_mem_fwd,
    input  risc16_pkg::result_fwd_t   i_wb_fwd,
    output risc16_pkg::exec_stage_t   o_exec,
    output risc16_pkg::word_t         o_mem_addr,
    output risc16_pkg::word_t         o_mem_wr_data,
    output logic                      o_mem_wr_en
);

    risc16_pkg::result_fwd_t exec_fwd;
    risc16_pkg::word_t       op1;
    risc16_pkg::word_t       op2;
    risc16_pkg::word_t       alu_a;
    risc16_pkg::word_t       alu_b;
    risc16_pkg::alu_op_e     alu_op;
    risc16_pkg::word_t       alu_result;
    risc16_pkg::exec_stage_t exec_next;

    // Only a live write to a real register can be forwarded
    function automatic logic fwd_hit(input risc16_pkg::reg_addr_t   src,
                                     input risc16_pkg::result_fwd_t fwd);
        return fwd.valid && (fwd.tgt != '0) && (fwd.tgt == src);
    endfunction

    // Youngest producer wins
    function automatic risc16_pkg::word_t fwd_select(input risc16_pkg::reg_addr_t   src,
                                                     input risc16_pkg::word_t       rf,
                                                     input risc16_pkg::result_fwd_t ex,
                                                     input risc16_pkg::result_fwd_t mem,
                                                     input risc16_pkg::result_fwd_t wb);
        if (fwd_hit(src, ex)) begin
            return ex.data;
        end else if (fwd_hit(src, mem)) begin
            return mem.data;
        end else if (fwd_hit(src, wb)) begin
            return wb.data;
        end
        return rf;
    endfunction

    // A load's ALU result is its address, not data
    assign exec_fwd.valid = o_exec.valid && !o_exec.is_load;
    assign exec_fwd.tgt   = o_exec.tgt;
    assign exec_fwd.data  = o_exec.alu_result;

    assign op1 = fwd_select(i_dec.src1, i_rd_data1, exec_fwd, i_mem_fwd, i_wb_fwd);
    assign op2 = fwd_select(i_dec.src2, i_rd_data2, exec_fwd, i_mem_fwd, i_wb_fwd);

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------
    always_comb begin
        alu_op = risc16_pkg::ALU_ADD;
        alu_a  = op1;
        alu_b  = op2;
        case (i_dec.opcode)
            risc16_pkg::OP_NAND: alu_op = risc16_pkg::ALU_NAND;
            risc16_pkg::OP_ADDI,
            risc16_pkg::OP_LW,
            risc16_pkg::OP_SW:   alu_b  = i_dec.imm;
            risc16_pkg::OP_LUI: begin
                alu_a = '0;
                alu_b = i_dec.imm;
            end
            default: alu_op = risc16_pkg::ALU_ADD;
        endcase
    end

    assign alu_result = (alu_op == risc16_pkg::ALU_NAND) ? ~(alu_a & alu_b) : alu_a + alu_b;

    // ----------------------------------------------------------------------
    // Execute register, a bubble goes in while the load-use stall is up
    // ----------------------------------------------------------------------
    always_comb begin
        exec_next            = '0;
        exec_next.valid      = i_dec.valid;
        exec_next.is_load    = i_dec.valid && (i_dec.opcode == risc16_pkg::OP_LW);
        exec_next.is_store   = i_dec.valid && (i_dec.opcode == risc16_pkg::OP_SW);
        exec_next.tgt        = i_dec.tgt;
        exec_next.alu_result = alu_result;
        exec_next.store_data = op2;
        if (i_stall) begin
            exec_next = '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_exec <= '0;
        end else begin
            o_exec <= exec_next;
        end
    end

    assign o_mem_addr    = o_exec.alu_result;
    assign o_mem_wr_data = o_exec.store_data;
    assign o_mem_wr_en   = o_exec.valid && o_exec.is_store;

endmodule

// File: hdl/risc16_mem_wb.sv
// Memory and writeback registers
// The memory register is the register file write request; both registers
// feed the forwarding muxes in execute
module risc16_mem_wb (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  risc16_pkg::exec_stage_t i_exec,
    input  risc16_pkg::word_t       i_mem_rd_data,
    output risc16_pkg::result_fwd_t o_mem_fwd,
    output risc16_pkg::result_fwd_t o_wb_fwd
);

    risc16_pkg::result_fwd_t mem_next;

    // Read data is valid while the load sits in the execute register
    always_comb begin
        mem_next.valid = i_exec.valid;
        mem_next.tgt   = i_exec.tgt;
        mem_next.data  = i_exec.is_load ? i_mem_rd_data : i_exec.alu_result;
    end

    // ----------------------------------------------------------------------
    // Memory register, then writeback register one cycle behind
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_fwd <= '0;
            o_wb_fwd  <= '0;
        end else begin
            o_mem_fwd <= mem_next;
            o_wb_fwd  <= o_mem_fwd;
        end
    end

endmodule

// File: hdl/risc16_core.sv
// Five-stage RiSC-16 core without branches
// Instruction and data memories sit outside and are read combinationally
module risc16_core (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  risc16_pkg::word_t i_inst,
    input  risc16_pkg::word_t i_mem_rd_data,
    output risc16_pkg::word_t o_pc,
    output risc16_pkg::word_t o_mem_addr,
    output risc16_pkg::word_t o_mem_wr_data,
    output logic              o_mem_wr_en
);

    logic                      load_stall;
    risc16_pkg::word_t         fetch_inst;
    logic                      fetch_valid;
    risc16_pkg::reg_addr_t     rd_src1;
    risc16_pkg::reg_addr_t     rd_src2;
    risc16_pkg::word_t         rd_data1;
    risc16_pkg::word_t         rd_data2;
    risc16_pkg::decode_stage_t dec_reg;
    risc16_pkg::exec_stage_t   exec_reg;
    risc16_pkg::result_fwd_t   mem_fwd;
    risc16_pkg::result_fwd_t   wb_fwd;

    risc16_fetch u_fetch (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_stall (load_stall),
        .i_inst  (i_inst),
        .o_pc    (o_pc),
        .o_inst  (fetch_inst),
        .o_valid (fetch_valid)
    );

    risc16_decode u_decode (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_inst       (fetch_inst),
        .i_valid      (fetch_valid),
        .i_exec       (exec_reg),
        .o_rd_src1    (rd_src1),
        .o_rd_src2    (rd_src2),
        .o_dec        (dec_reg),
        .o_load_stall (load_stall)
    );

    // Memory register result is the write request
    risc16_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rd_src1  (rd_src1),
        .i_rd_src2  (rd_src2),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2),
        .i_wr       (mem_fwd)
    );

    risc16_execute u_execute (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (load_stall),
        .i_dec         (dec_reg),
        .i_rd_data1    (rd_data1),
        .i_rd_data2    (rd_data2),
        .i_mem_fwd     (mem_fwd),
        .i_wb_fwd      (wb_fwd),
        .o_exec        (exec_reg),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en)
    );

    risc16_mem_wb u_mem_wb (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_exec        (exec_reg),
        .i_mem_rd_data (i_mem_rd_data),
        .o_mem_fwd     (mem_fwd),
        .o_wb_fwd      (wb_fwd)
    );

endmodule

// File: testbench/risc16_sva.sv
// Concurrent checks on reset, the load-use stall and bubble flow
// Attached to every risc16_core instance through the bind below
module risc16_sva (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              i_load_stall,
    input risc16_pkg::word_t i_pc,
    input logic              i_mem_wr_en,
    input logic              i_fetch_valid,
    input logic              i_dec_valid,
    input logic              i_exec_valid,
    input logic              i_mem_valid,
    input logic              i_wb_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------------
    // Reset and stall
    // ------------------------------------------------------------------
    reset_no_store: assert property (@(posedge i_clk) !i_rst_n |-> !i_mem_wr_en)
        else $error("store enable high during reset");

    stall_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_load_stall |=> !i_load_stall)
        else $error("load-use stall held for more than one cycle");

    stall_pc_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_load_stall |=> $stable(i_pc))
        else $error("PC moved during a load-use stall");

    // Stall pushes a bubble into execute
    stall_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_load_stall |=> !i_exec_valid)
        else $error("execute register valid after a stall cycle");

    // ------------------------------------------------------------------
    // Bubbles move one stage per cycle
    // ------------------------------------------------------------------
    fetch_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_fetch_valid && !i_load_stall) |=> !i_dec_valid)
        else $error("fetch bubble did not reach decode");

    dec_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_dec_valid |=> !i_exec_valid)
        else $error("decode bubble did not reach execute");

    exec_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_exec_valid |=> !i_mem_valid)
        else $error("execute bubble did not reach memory");

    mem_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_mem_valid |=> !i_wb_valid)
        else $error("memory bubble did not reach writeback");

endmodule

bind risc16_core risc16_sva u_sva (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_load_stall  (load_stall),
    .i_pc          (o_pc),
    .i_mem_wr_en   (o_mem_wr_en),
    .i_fetch_valid (fetch_valid),
    .i_dec_valid   (dec_reg.valid),
    .i_exec_valid  (exec_reg.valid),
    .i_mem_valid   (mem_fwd.valid),
    .i_wb_valid    (wb_fwd.valid)
);

// File: testbench/tb_risc16.sv
// Testbench for the RiSC-16 core
// Program, initial data and expected stores come from testbench/risc16_tests.dat;
// both memories are modelled here and every store is checked in order
module tb_risc16;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_DEPTH    = 256;
    localparam int MAX_STORES    = 64;
    localparam int STORE_TIMEOUT = 2000;
    localparam int DRAIN_CYCLES  = 16;

    logic              clk;
    logic              rst_n;
    risc16_pkg::word_t inst;
    risc16_pkg::word_t mem_rd_data;
    risc16_pkg::word_t pc;
    risc16_pkg::word_t mem_addr;
    risc16_pkg::word_t mem_wr_data;
    logic              mem_wr_en;

    risc16_pkg::word_t imem     [0:IMEM_DEPTH-1];
    risc16_pkg::word_t dmem     [0:65535];
    risc16_pkg::word_t exp_addr [0:MAX_STORES-1];
    risc16_pkg::word_t exp_data [0:MAX_STORES-1];

    int n_prog       = 0;
    int n_exp        = 0;
    int n_stores     = 0;
    int value_errors = 0;
    int other_errors = 0;

    risc16_core u_dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_inst        (inst),
        .i_mem_rd_data (mem_rd_data),
        .o_pc          (pc),
        .o_mem_addr    (mem_addr),
        .o_mem_wr_data (mem_wr_data),
        .o_mem_wr_en   (mem_wr_en)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // Test file loading and checks
    // ------------------------------------------------------------------
    task automatic load_tests();
        int                fd;
        int                code;
        int                ch;
        logic [31:0]       tag;
        risc16_pkg::word_t addr;
        risc16_pkg::word_t data;
        logic              done;
        fd = $fopen("testbench/risc16_tests.dat", "r");
        if (fd == 0) begin
            $display("ERROR: could not open testbench/risc16_tests.dat");
            other_errors++;
            return;
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                // Comment runs to the end of the line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (tag == "P" && n_prog < IMEM_DEPTH) begin
                code = $fscanf(fd, "%h", data);
                imem[n_prog] = data;
                n_prog++;
            end else if (tag == "D") begin
                code = $fscanf(fd, "%h %h", addr, data);
                dmem[addr] = data;
            end else if (tag == "S" && n_exp < MAX_STORES) begin
                code = $fscanf(fd, "%h %h", addr, data);
                exp_addr[n_exp] = addr;
                exp_data[n_exp] = data;
                n_exp++;
            end else begin
                $display("ERROR: unknown tag or table full in the test file");
                other_errors++;
                done = 1'b1;
            end
        end
        $fclose(fd);
        if (n_exp == 0) begin
            $display("ERROR: the test file lists no expected stores");
            other_errors++;
        end
    endtask

    task automatic check_store(input risc16_pkg::word_t addr, input risc16_pkg::word_t data,
                               input risc16_pkg::word_t exp_a, input risc16_pkg::word_t exp_d);
        if (addr !== exp_a || data !== exp_d) begin
            $display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, n_stores, data, addr, exp_d, exp_a);
            value_errors++;
        end
    endtask

    task automatic check_pc(input risc16_pkg::word_t got, input risc16_pkg::word_t expected);
        if (got !== expected) begin
            $display("FAIL %0t: PC is %h, expected %h", $time, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_count(input int got, input int expected);
        if (got != expected) begin
            $display("FAIL %0t: saw %0d stores, expected %0d", $time, got, expected);
            value_errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // Memory models, driven on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && mem_wr_en) begin
            if (n_stores < n_exp) begin
                check_store(mem_addr, mem_wr_data, exp_addr[n_stores], exp_data[n_stores]);
            end else begin
                $display("ERROR: store to %h beyond the expected sequence at %0t",
                         mem_addr, $time);
                other_errors++;
            end
            dmem[mem_addr] = mem_wr_data;
            n_stores++;
        end
        // Past the program the core sees ADD r0,r0,r0
        inst        <= (int'(pc) < n_prog) ? imem[pc[7:0]] : '0;
        mem_rd_data <= dmem[mem_addr];
    end

    initial begin : main
        int cycles;
        rst_n       = 1'b0;
        inst        = '0;
        mem_rd_data = '0;
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = risc16_pkg::word_t'(a) ^ 16'hC3C3;
        end
        load_tests();
        repeat (3) @(posedge clk);
        @(negedge clk);
        // PC sits at zero while reset is low
        check_pc(pc, 16'h0000);
        rst_n = 1'b1;

        // First cycle out of reset cannot stall
        @(negedge clk);
        check_pc(pc, 16'h0001);

        cycles = 0;
        while (n_stores < n_exp && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (n_stores < n_exp) begin
            $display("ERROR: timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, n_stores, n_exp);
            other_errors++;
        end
        // Let any stray store show up
        repeat (DRAIN_CYCLES) @(posedge clk);
        check_count(n_stores, n_exp);

        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/risc16_pkg.sv
hdl/risc16_fetch.sv
hdl/risc16_decode.sv
hdl/risc16_regfile.sv
hdl/risc16_execute.sv
hdl/risc16_mem_wb.sv
hdl/risc16_core.sv
testbench/risc16_sva.sv
testbench/tb_risc16.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the RiSC-16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_risc16 -f vlog.f --Mdir obj_dir -o sim_risc16
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_risc16 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Run passed"
    exit 0
fi
echo "Run failed, see sim.log"
exit 1

// File: testbench/risc16_tests.dat
# P word: program word in hex from address 0 up; D addr word: initial data memory
# S addr word: expected store in program order; text after a lone # is ignored
P 2405 # addi r1, r0, 5
P 287D # addi r2, r0, -3
P 0C82 # add  r3, r1, r2     r2 from execute, r1 from memory
P 8C10 # sw   r3, r0, 16
P 5082 # nand r4, r1, r2     r2 from writeback
P 76B5 # lui  r5, 0x2B5
P 36BF # addi r5, r5, 0x3F   builds 0xAD7F
P 9011 # sw   r4, r0, 17
P 9412 # sw   r5, r0, 18
P B820 # lw   r6, r0, 32
P 1F01 # add  r7, r6, r1     load-use stall
P 9C13 # sw   r7, r0, 19
P A821 # lw   r2, r0, 33
P 8814 # sw   r2, r0, 20     store of loaded data
P 2087 # addi r0, r1, 7      discarded
P 8015 # sw   r0, r0, 21
P 2440 # addi r1, r0, -64
P 6C01 # lui  r3, 0x001
P 5081 # nand r4, r1, r1
P 91D6 # sw   r4, r3, -42
P B5E2 # lw   r5, r3, -30
P 1A85 # add  r6, r5, r5     load-use stall
P BC10 # lw   r7, r0, 16     reads back the first store
P 9B95 # sw   r6, r7, 21     base from a load
D 0010 5555
D 0020 1234
D 0021 BEEF
D 0022 0F0F
S 0010 0002
S 0011 FFFA
S 0012 AD7F
S 0013 1239
S 0014 BEEF
S 0015 0000
S 0016 003F
S 0017 1E1E
